// ==== design/dac_lane_pkg.sv ====
// ******************************
// dac lane package
// datapath constants and the sample type shared by
// every stage of the dac channel
// ******************************

package dac_lane_pkg;

  // ******************************
  // datapath geometry
  // ******************************

  // parallel samples per dac_div_clk cycle
  localparam int LANES_DEF = 16;

  // sample, phase and setting width
  localparam int SAMPLE_W_DEF = 16;

  // log2 of LANES_DEF, the per-clock phase stride is incr << LANE_SHIFT
  localparam int LANE_SHIFT = 4;

  // ******************************
  // types
  // ******************************

  // one sample or one setting word
  typedef logic [SAMPLE_W_DEF-1:0] sample_t;

endpackage

// ==== design/dac_ctrl_pkg.sv ====
// ******************************
// dac control package
// source select and dds output format encodings
// ******************************

package dac_ctrl_pkg;

  // output source select
  // unlisted codes fall back to the dds
  typedef enum logic [3:0] {
    SEL_DDS     = 4'd0,
    SEL_PATTERN = 4'd1,
    SEL_DMA     = 4'd2
  } data_sel_e;

  // dds sample format
  // offset binary is two's complement with the msb inverted
  typedef enum logic {
    FMT_TWOS   = 1'b0,
    FMT_OFFSET = 1'b1
  } dds_format_e;

endpackage

// ==== design/dds_phase_accum.sv ====
// ******************************
// dds phase accumulator
// two phase accumulators per lane, seeded on sync and
// advanced by LANES increments every clock
// ******************************

`timescale 1ns/1ps

module dds_phase_accum #(
  parameter int LANES    = dac_lane_pkg::LANES_DEF,
  parameter int SAMPLE_W = dac_lane_pkg::SAMPLE_W_DEF
) (
  input  logic                           dac_div_clk,
  input  logic                           i_arst_n,
  input  logic                           i_sync,
  input  dac_lane_pkg::sample_t          i_init_1,
  input  dac_lane_pkg::sample_t          i_init_2,
  input  dac_lane_pkg::sample_t          i_incr_1,
  input  dac_lane_pkg::sample_t          i_incr_2,
  output logic [LANES-1:0][SAMPLE_W-1:0] o_phase_1,
  output logic [LANES-1:0][SAMPLE_W-1:0] o_phase_2,
  output logic                           o_sync_d
);

  import dac_lane_pkg::*;

  localparam int STRIDE_SHIFT = $clog2(LANES);

  sample_t                        stride_1;
  sample_t                        stride_2;
  logic [LANES-1:0][SAMPLE_W-1:0] seed_1;
  logic [LANES-1:0][SAMPLE_W-1:0] seed_2;

  // all lanes move together by LANES sample steps
  assign stride_1 = i_incr_1 << STRIDE_SHIFT;
  assign stride_2 = i_incr_2 << STRIDE_SHIFT;

  // lane k starts k sample steps after lane 0
  for (genvar k = 0; k < LANES; k++) begin : g_seed
    assign seed_1[k] = i_init_1 + SAMPLE_W'(k) * i_incr_1;
    assign seed_2[k] = i_init_2 + SAMPLE_W'(k) * i_incr_2;
  end

  always_ff @(posedge dac_div_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_phase_1 <= '0;
      o_phase_2 <= '0;
      o_sync_d  <= 1'b0;
    end else begin
      o_sync_d <= i_sync;
      if (i_sync) begin
        o_phase_1 <= seed_1;
        o_phase_2 <= seed_2;
      end else begin
        for (int k = 0; k < LANES; k++) begin
          o_phase_1[k] <= o_phase_1[k] + stride_1;
          o_phase_2[k] <= o_phase_2[k] + stride_2;
        end
      end
    end
  end

  // ******************************
  // checks
  // ******************************

  // adjacent lanes sit one increment apart right after seeding
  if (LANES > 1) begin : g_seed_chk
    a_seed_step : assert property (
      @(posedge dac_div_clk) disable iff (!i_arst_n)
      i_sync |=> (SAMPLE_W'(o_phase_1[1] - o_phase_1[0]) == $past(i_incr_1)) &&
                 (SAMPLE_W'(o_phase_2[1] - o_phase_2[0]) == $past(i_incr_2))
    );
  end

endmodule

// ==== design/dds_tone_shaper.sv ====
// ******************************
// dds tone shaper
// triangle phase-to-amplitude, scaling and two-tone sum
// per lane, with the output format applied
// ******************************

`timescale 1ns/1ps

module dds_tone_shaper #(
  parameter int LANES    = dac_lane_pkg::LANES_DEF,
  parameter int SAMPLE_W = dac_lane_pkg::SAMPLE_W_DEF
) (
  input  logic                           dac_div_clk,
  input  logic                           i_arst_n,
  input  logic [LANES-1:0][SAMPLE_W-1:0] i_phase_1,
  input  logic [LANES-1:0][SAMPLE_W-1:0] i_phase_2,
  input  logic                           i_sync_d,
  input  dac_lane_pkg::sample_t          i_scale_1,
  input  dac_lane_pkg::sample_t          i_scale_2,
  input  dac_ctrl_pkg::dds_format_e      i_format,
  output logic [LANES-1:0][SAMPLE_W-1:0] o_dds_data
);

  import dac_ctrl_pkg::*;

  // midpoint of the folded phase, subtracted to center the triangle
  localparam logic [SAMPLE_W-1:0] HALF_SCALE = 1 << (SAMPLE_W-2);

  logic [LANES-1:0][SAMPLE_W-1:0] shaped;

  // triangle amplitude of one tone, scale of 2^(SAMPLE_W-1) is unity
  function automatic logic [SAMPLE_W-1:0] tone_amp(
    input logic [SAMPLE_W-1:0] phase,
    input logic [SAMPLE_W-1:0] scale
  );
    logic [SAMPLE_W-2:0]        tri_mag;
    logic signed [SAMPLE_W-1:0] amp;
    logic signed [2*SAMPLE_W:0] prod;
    // fold the upper half of the cycle back down
    tri_mag = phase[SAMPLE_W-1] ? ~phase[SAMPLE_W-2:0] : phase[SAMPLE_W-2:0];
    amp     = $signed({1'b0, tri_mag}) - $signed(HALF_SCALE);
    prod    = amp * $signed({1'b0, scale});
    // arithmetic shift right by SAMPLE_W-1, kept to SAMPLE_W bits
    return prod[SAMPLE_W-1 +: SAMPLE_W];
  endfunction

  for (genvar k = 0; k < LANES; k++) begin : g_lane
    logic [SAMPLE_W-1:0] tone_sum;

    // two's complement sum, wraps on overflow
    assign tone_sum = tone_amp(i_phase_1[k], i_scale_1) +
                      tone_amp(i_phase_2[k], i_scale_2);

    assign shaped[k] = {tone_sum[SAMPLE_W-1] ^ (i_format == FMT_OFFSET),
                        tone_sum[SAMPLE_W-2:0]};
  end

  // lanes are muted while the accumulators are being seeded
  always_ff @(posedge dac_div_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_dds_data <= '0;
    end else if (i_sync_d) begin
      o_dds_data <= '0;
    end else begin
      o_dds_data <= shaped;
    end
  end

  // ******************************
  // checks
  // ******************************

  a_sync_mute : assert property (
    @(posedge dac_div_clk) disable iff (!i_arst_n)
    i_sync_d |=> (o_dds_data == '0)
  );

endmodule

// ==== design/dac_source_select.sv ====
// ******************************
// dac source select
// registered mux among dma, test pattern and dds,
// with the dma data-enable strobe
// ******************************

`timescale 1ns/1ps

module dac_source_select #(
  parameter int LANES    = dac_lane_pkg::LANES_DEF,
  parameter int SAMPLE_W = dac_lane_pkg::SAMPLE_W_DEF
) (
  input  logic                           dac_div_clk,
  input  logic                           i_arst_n,
  input  dac_ctrl_pkg::data_sel_e        i_data_sel,
  input  logic [LANES-1:0][SAMPLE_W-1:0] i_dds_data,
  input  logic [LANES-1:0][SAMPLE_W-1:0] i_dma_data,
  input  dac_lane_pkg::sample_t          i_pat_data_1,
  input  dac_lane_pkg::sample_t          i_pat_data_2,
  output logic [LANES-1:0][SAMPLE_W-1:0] o_data,
  output logic                           o_enable
);

  import dac_ctrl_pkg::*;

  logic [LANES-1:0][SAMPLE_W-1:0] pat_vec;

  // even lanes carry the first word, odd lanes the second
  for (genvar k = 0; k < LANES; k++) begin : g_pat
    assign pat_vec[k] = ((k % 2) == 0) ? i_pat_data_1 : i_pat_data_2;
  end

  always_ff @(posedge dac_div_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_data   <= '0;
      o_enable <= 1'b0;
    end else begin
      o_enable <= (i_data_sel == SEL_DMA);
      case (i_data_sel)
        SEL_DMA: begin
          o_data <= i_dma_data;
        end
        SEL_PATTERN: begin
          o_data <= pat_vec;
        end
        // reserved codes fall through to the dds
        default: begin
          o_data <= i_dds_data;
        end
      endcase
    end
  end

  // ******************************
  // checks
  // ******************************

  // the strobe marks exactly the words taken from dma
  a_enable_dma : assert property (
    @(posedge dac_div_clk) disable iff (!i_arst_n)
    o_enable |-> ($past(i_data_sel) == SEL_DMA) && (o_data == $past(i_dma_data))
  );

endmodule

// ==== design/dac_channel_top.sv ====
// ******************************
// dac channel
// one dac channel, LANES samples per clock, fed from
// dma, a test pattern or a two-tone dds
// ******************************

`timescale 1ns/1ps

module dac_channel_top #(
  parameter int LANES    = dac_lane_pkg::LANES_DEF,
  parameter int SAMPLE_W = dac_lane_pkg::SAMPLE_W_DEF
) (
  input  logic                           dac_div_clk,
  input  logic                           i_arst_n,

  // control levels
  input  logic                           i_sync,
  input  dac_ctrl_pkg::data_sel_e        i_data_sel,
  input  dac_ctrl_pkg::dds_format_e      i_format,

  // dds tone settings
  input  dac_lane_pkg::sample_t          i_dds_init_1,
  input  dac_lane_pkg::sample_t          i_dds_init_2,
  input  dac_lane_pkg::sample_t          i_dds_incr_1,
  input  dac_lane_pkg::sample_t          i_dds_incr_2,
  input  dac_lane_pkg::sample_t          i_dds_scale_1,
  input  dac_lane_pkg::sample_t          i_dds_scale_2,

  // pattern words and dma samples
  input  dac_lane_pkg::sample_t          i_pat_data_1,
  input  dac_lane_pkg::sample_t          i_pat_data_2,
  input  logic [LANES-1:0][SAMPLE_W-1:0] i_dma_data,

  output logic [LANES-1:0][SAMPLE_W-1:0] o_data,
  output logic                           o_enable
);

  logic [LANES-1:0][SAMPLE_W-1:0] phase_1;
  logic [LANES-1:0][SAMPLE_W-1:0] phase_2;
  logic                           sync_d;
  logic [LANES-1:0][SAMPLE_W-1:0] dds_data;

  // stage 1
  dds_phase_accum #(
    .LANES    (LANES),
    .SAMPLE_W (SAMPLE_W)
  ) u_phase_accum (
    .dac_div_clk (dac_div_clk),
    .i_arst_n    (i_arst_n),
    .i_sync      (i_sync),
    .i_init_1    (i_dds_init_1),
    .i_init_2    (i_dds_init_2),
    .i_incr_1    (i_dds_incr_1),
    .i_incr_2    (i_dds_incr_2),
    .o_phase_1   (phase_1),
    .o_phase_2   (phase_2),
    .o_sync_d    (sync_d)
  );

  // stage 2
  dds_tone_shaper #(
    .LANES    (LANES),
    .SAMPLE_W (SAMPLE_W)
  ) u_tone_shaper (
    .dac_div_clk (dac_div_clk),
    .i_arst_n    (i_arst_n),
    .i_phase_1   (phase_1),
    .i_phase_2   (phase_2),
    .i_sync_d    (sync_d),
    .i_scale_1   (i_dds_scale_1),
    .i_scale_2   (i_dds_scale_2),
    .i_format    (i_format),
    .o_dds_data  (dds_data)
  );

  // stage 3
  dac_source_select #(
    .LANES    (LANES),
    .SAMPLE_W (SAMPLE_W)
  ) u_source_select (
    .dac_div_clk  (dac_div_clk),
    .i_arst_n     (i_arst_n),
    .i_data_sel   (i_data_sel),
    .i_dds_data   (dds_data),
    .i_dma_data   (i_dma_data),
    .i_pat_data_1 (i_pat_data_1),
    .i_pat_data_2 (i_pat_data_2),
    .o_data       (o_data),
    .o_enable     (o_enable)
  );

endmodule

// ==== dv/tb_dac_channel.sv ====
// ******************************
// dac channel testbench
// table-driven checks of the dma, pattern and dds
// paths against a model of the tone rules
// ******************************

`timescale 1ns/1ps

module tb_dac_channel;

  import dac_lane_pkg::*;
  import dac_ctrl_pkg::*;

  localparam int LANES      = LANES_DEF;
  localparam int VEC_W      = LANES * SAMPLE_W_DEF;
  localparam int CLK_PERIOD = 20;
  localparam int EDGE_LIMIT = 2 * CLK_PERIOD;
  localparam int NUM_ROWS   = 7;

  typedef logic [LANES-1:0][SAMPLE_W_DEF-1:0] lane_vec_t;

  typedef struct packed {
    logic [3:0] sel;
    logic       fmt;
    sample_t    init_1;
    sample_t    init_2;
    sample_t    incr_1;
    sample_t    incr_2;
    sample_t    scale_1;
    sample_t    scale_2;
    sample_t    pat_1;
    sample_t    pat_2;
    logic [7:0] sync_len;
    logic [7:0] n_check;
  } row_t;

  logic        dac_div_clk;
  logic        i_arst_n;
  logic        i_sync;
  data_sel_e   i_data_sel;
  dds_format_e i_format;
  sample_t     i_dds_init_1;
  sample_t     i_dds_init_2;
  sample_t     i_dds_incr_1;
  sample_t     i_dds_incr_2;
  sample_t     i_dds_scale_1;
  sample_t     i_dds_scale_2;
  sample_t     i_pat_data_1;
  sample_t     i_pat_data_2;
  lane_vec_t   i_dma_data;
  lane_vec_t   o_data;
  logic        o_enable;

  row_t        rows [NUM_ROWS];
  logic [15:0] lfsr_state;
  bit          edge_seen;

  dac_channel_top u_dac_channel_top (
    .dac_div_clk   (dac_div_clk),
    .i_arst_n      (i_arst_n),
    .i_sync        (i_sync),
    .i_data_sel    (i_data_sel),
    .i_format      (i_format),
    .i_dds_init_1  (i_dds_init_1),
    .i_dds_init_2  (i_dds_init_2),
    .i_dds_incr_1  (i_dds_incr_1),
    .i_dds_incr_2  (i_dds_incr_2),
    .i_dds_scale_1 (i_dds_scale_1),
    .i_dds_scale_2 (i_dds_scale_2),
    .i_pat_data_1  (i_pat_data_1),
    .i_pat_data_2  (i_pat_data_2),
    .i_dma_data    (i_dma_data),
    .o_data        (o_data),
    .o_enable      (o_enable)
  );

  initial begin
    dac_div_clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) dac_div_clk = ~dac_div_clk;
    end
  end

  // ******************************
  // helpers
  // ******************************

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "testbench stopped");
  endtask

  task automatic check_value(input logic [VEC_W-1:0] expected,
                             input logic [VEC_W-1:0] actual,
                             input string           what);
    if (actual !== expected) begin
      fail_run($sformatf("Fail at %0d ns: %s, expected %h, got %h",
                         $time, what, expected, actual));
    end
  endtask

  // wait for one falling edge but give up if the clock stalls
  task next_fall();
    edge_seen = 1'b0;
    fork
      begin
        @(negedge dac_div_clk);
        edge_seen = 1'b1;
      end
      begin
        #(EDGE_LIMIT);
      end
    join_any
    disable fork;
    if (!edge_seen) begin
      fail_run($sformatf("the clock did not fall within %0d ns", EDGE_LIMIT));
    end
  endtask

  // 16-bit fibonacci lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic random_vector(output lane_vec_t vec);
    vec = '0;
    for (int k = 0; k < LANES; k++) begin
      for (int b = 0; b < SAMPLE_W_DEF; b++) begin
        lfsr_state = lfsr_next(lfsr_state);
        vec[k][b]  = lfsr_state[0];
      end
    end
  endtask

  // ******************************
  // reference model
  // ******************************

  // triangle level of one tone where a scale of 32768 is unity
  function automatic sample_t tone_level(input sample_t phase, input sample_t scale);
    logic [14:0] fold;
    int          amp;
    int          gain;
    int          prod;
    fold = phase[15] ? ~phase[14:0] : phase[14:0];
    amp  = fold;
    amp  = amp - 16384;
    gain = scale;
    prod = amp * gain;
    prod = prod >>> 15;
    return prod[15:0];
  endfunction

  function automatic lane_vec_t dds_vector(input row_t r, input int steps);
    lane_vec_t vec;
    sample_t   p1;
    sample_t   p2;
    sample_t   sum;
    for (int k = 0; k < LANES; k++) begin
      // lane k seed moved on by steps strides of LANES increments
      p1  = r.init_1 + k * r.incr_1 + steps * LANES * r.incr_1;
      p2  = r.init_2 + k * r.incr_2 + steps * LANES * r.incr_2;
      sum = tone_level(p1, r.scale_1) + tone_level(p2, r.scale_2);
      if (r.fmt == FMT_OFFSET) begin
        sum[15] = ~sum[15];
      end
      vec[k] = sum;
    end
    return vec;
  endfunction

  function automatic lane_vec_t pattern_vector(input sample_t w1, input sample_t w2);
    lane_vec_t vec;
    for (int k = 0; k < LANES; k++) begin
      vec[k] = (k % 2 == 0) ? w1 : w2;
    end
    return vec;
  endfunction

  // ******************************
  // stimulus table
  // ******************************

  function automatic row_t make_row(input logic [3:0] sel,
                                    input logic       fmt,
                                    input sample_t    init_1,
                                    input sample_t    init_2,
                                    input sample_t    incr_1,
                                    input sample_t    incr_2,
                                    input sample_t    scale_1,
                                    input sample_t    scale_2,
                                    input sample_t    pat_1,
                                    input sample_t    pat_2,
                                    input int         sync_len,
                                    input int         n_check);
    row_t r;
    r = '{sel, fmt, init_1, init_2, incr_1, incr_2, scale_1, scale_2,
          pat_1, pat_2, sync_len[7:0], n_check[7:0]};
    return r;
  endfunction

  task automatic load_table();
    // sel, fmt, init 1/2, incr 1/2, scale 1/2, pattern 1/2, sync cycles, check cycles
    rows[0] = make_row(SEL_DMA, FMT_TWOS, 0, 0, 0, 0, 0, 0, 0, 0, 0, 8);
    rows[1] = make_row(SEL_PATTERN, FMT_TWOS, 0, 0, 0, 0, 0, 0, 16'h1234, 16'hA5C3, 0, 3);
    rows[2] = make_row(SEL_PATTERN, FMT_TWOS, 0, 0, 0, 0, 0, 0, 16'h8001, 16'h7FFE, 0, 3);
    rows[3] = make_row(SEL_DDS, FMT_TWOS, 16'h0000, 16'h4000, 16'h0123, 16'h0A50,
                       16'h8000, 16'h2000, 0, 0, 4, 20);
    rows[4] = make_row(SEL_DDS, FMT_TWOS, 16'hC000, 16'h1357, 16'h0F0F, 16'h0011,
                       16'h6000, 16'h7FFF, 0, 0, 3, 20);
    rows[5] = make_row(SEL_DDS, FMT_OFFSET, 16'h0000, 16'h4000, 16'h0123, 16'h0A50,
                       16'h8000, 16'h2000, 0, 0, 4, 12);
    // reserved select code
    rows[6] = make_row(4'd3, FMT_TWOS, 16'hC000, 16'h1357, 16'h0F0F, 16'h0011,
                       16'h6000, 16'h7FFF, 0, 0, 3, 10);
  endtask

  task automatic run_dma(input int idx, input row_t r);
    lane_vec_t sent;
    random_vector(sent);
    i_dma_data = sent;
    for (int c = 0; c < r.n_check; c++) begin
      next_fall();
      check_value(sent, o_data, $sformatf("row %0d dma word %0d", idx, c));
      check_value(1, o_enable, $sformatf("row %0d dma enable %0d", idx, c));
      random_vector(sent);
      i_dma_data = sent;
    end
  endtask

  task automatic run_pattern(input int idx, input row_t r);
    for (int c = 0; c < r.n_check; c++) begin
      next_fall();
      check_value(pattern_vector(r.pat_1, r.pat_2), o_data,
                  $sformatf("row %0d pattern cycle %0d", idx, c));
      check_value(0, o_enable, $sformatf("row %0d pattern enable %0d", idx, c));
    end
  endtask

  task automatic run_dds(input int idx, input row_t r);
    lane_vec_t expected;
    i_sync = 1'b1;
    for (int c = 1; c <= r.sync_len; c++) begin
      next_fall();
      // muted output reaches the pins on the third held cycle
      if (c >= 3) begin
        check_value(0, o_data, $sformatf("row %0d sync hold cycle %0d", idx, c));
      end
      check_value(0, o_enable, $sformatf("row %0d sync enable %0d", idx, c));
    end
    i_sync = 1'b0;
    for (int j = 1; j <= r.n_check; j++) begin
      next_fall();
      if (j <= 2) begin
        expected = '0;
      end else begin
        expected = dds_vector(r, j - 2);
      end
      check_value(expected, o_data, $sformatf("row %0d dds cycle %0d", idx, j));
      check_value(0, o_enable, $sformatf("row %0d dds enable %0d", idx, j));
    end
  endtask

  task automatic apply_row(input int idx, input row_t r);
    i_data_sel    = data_sel_e'(r.sel);
    i_format      = dds_format_e'(r.fmt);
    i_dds_init_1  = r.init_1;
    i_dds_init_2  = r.init_2;
    i_dds_incr_1  = r.incr_1;
    i_dds_incr_2  = r.incr_2;
    i_dds_scale_1 = r.scale_1;
    i_dds_scale_2 = r.scale_2;
    i_pat_data_1  = r.pat_1;
    i_pat_data_2  = r.pat_2;
    if (r.sel == SEL_DMA) begin
      run_dma(idx, r);
    end else if (r.sel == SEL_PATTERN) begin
      run_pattern(idx, r);
    end else begin
      run_dds(idx, r);
    end
  endtask

  // ******************************
  // main sequence
  // ******************************

  initial begin
    lfsr_state    = 16'd97;
    i_arst_n      = 1'b0;
    i_sync        = 1'b0;
    i_data_sel    = SEL_DDS;
    i_format      = FMT_TWOS;
    i_dds_init_1  = '0;
    i_dds_init_2  = '0;
    i_dds_incr_1  = '0;
    i_dds_incr_2  = '0;
    i_dds_scale_1 = '0;
    i_dds_scale_2 = '0;
    i_pat_data_1  = '0;
    i_pat_data_2  = '0;
    i_dma_data    = '0;
    load_table();

    for (int c = 0; c < 3; c++) begin
      next_fall();
      check_value(0, o_data, $sformatf("o_data in reset cycle %0d", c));
      check_value(0, o_enable, $sformatf("o_enable in reset cycle %0d", c));
    end
    i_arst_n = 1'b1;
    // zero scale keeps the dds quiet right after reset
    for (int c = 0; c < 2; c++) begin
      next_fall();
      check_value(0, o_data, $sformatf("o_data after reset cycle %0d", c));
      check_value(0, o_enable, $sformatf("o_enable after reset cycle %0d", c));
    end

    for (int n = 0; n < NUM_ROWS; n++) begin
      apply_row(n, rows[n]);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

// ==== vlog.f ====
design/dac_lane_pkg.sv
design/dac_ctrl_pkg.sv
design/dds_phase_accum.sv
design/dds_tone_shaper.sv
design/dac_source_select.sv
design/dac_channel_top.sv
dv/tb_dac_channel.sv

// ==== Bender.yml ====
package:
  name: dac_channel

sources:
  - files:
      - design/dac_lane_pkg.sv
      - design/dac_ctrl_pkg.sv
      - design/dds_phase_accum.sv
      - design/dds_tone_shaper.sv
      - design/dac_source_select.sv
      - design/dac_channel_top.sv
  - target: test
    files:
      - dv/tb_dac_channel.sv
